// File: hw/snes_cart_cfg.svh
`ifndef SNES_CART_CFG_SVH
`define SNES_CART_CFG_SVH

// Download port
`define SNES_ADDR_W         25
`define SNES_DATA_W         16
`define SNES_CODE_INDEX     8'hFF

// Address masks and backup RAM sectors
`define SNES_MASK_W         24
`define SNES_LBA_W          32
`define SNES_SECTOR_SHIFT   9

// Flags, address, compare, replace
`define SNES_CHEAT_W        128

// Internal header locations, before the copier header
`define SNES_COPIER_HDR        25'h000200
`define SNES_LOROM_SIZE_ADDR   25'h007FD6
`define SNES_LOROM_RAM_ADDR    25'h007FD8
`define SNES_HIROM_SIZE_ADDR   25'h00FFD6
`define SNES_HIROM_RAM_ADDR    25'h00FFD8
`define SNES_EXHIROM_SIZE_ADDR 25'h40FFD6
`define SNES_EXHIROM_RAM_ADDR  25'h40FFD8

// Size nibble when the image carries no size byte
`define SNES_DEFAULT_ROM_SIZE  4'hC

`endif

// File: hw/snes_cart_pkg.sv
`include "snes_cart_cfg.svh"

package snes_cart_pkg;

	// Header layout chosen from the menu
	typedef enum logic [2:0] {
		HDR_AUTO    = 3'd0,
		HDR_NONE    = 3'd1,
		HDR_LOROM   = 3'd2,
		HDR_HIROM   = 3'd3,
		HDR_EXHIROM = 3'd4
	} header_mode_e;

	// Backup RAM transfer states
	typedef enum logic [1:0] {
		BK_IDLE      = 2'd0,
		BK_WAIT_ACK  = 2'd1,
		BK_WAIT_DONE = 2'd2
	} bk_state_e;

	// ROM and RAM address masks
	typedef logic [`SNES_MASK_W-1:0] addr_mask_t;

endpackage

// File: hw/rom_header_detect.sv
`timescale 1ns/100ps
`include "snes_cart_cfg.svh"

module rom_header_detect (
	input  logic                            clk_sys,
	input  logic                            reset,
	input  logic                            cart_download,
	input  logic                            ioctl_wr,
	input  logic [`SNES_ADDR_W-1:0]         ioctl_addr,
	input  logic [`SNES_DATA_W-1:0]         ioctl_dout,
	input  snes_cart_pkg::header_mode_e     header_mode,
	output logic [7:0]                      rom_type,
	output snes_cart_pkg::addr_mask_t       rom_mask,
	output snes_cart_pkg::addr_mask_t       ram_mask,
	output logic                            rom_region
);

	localparam snes_cart_pkg::addr_mask_t mask_base = 1024;

	logic [3:0] rom_size;
	logic [3:0] ram_size;

	// Size byte locations of the forced layout
	logic [`SNES_ADDR_W-1:0] size_addr;
	logic [`SNES_ADDR_W-1:0] ram_addr;
	logic                    layout_forced;
	logic                    hdr_wr;

	assign hdr_wr = cart_download & ioctl_wr;

	always_comb begin
		size_addr = '0;
		ram_addr = '0;
		layout_forced = 1'b0;
		case (header_mode)
			snes_cart_pkg::HDR_LOROM: begin
				size_addr = `SNES_LOROM_SIZE_ADDR + `SNES_COPIER_HDR;
				ram_addr = `SNES_LOROM_RAM_ADDR + `SNES_COPIER_HDR;
				layout_forced = 1'b1;
			end
			snes_cart_pkg::HDR_HIROM: begin
				size_addr = `SNES_HIROM_SIZE_ADDR + `SNES_COPIER_HDR;
				ram_addr = `SNES_HIROM_RAM_ADDR + `SNES_COPIER_HDR;
				layout_forced = 1'b1;
			end
			snes_cart_pkg::HDR_EXHIROM: begin
				size_addr = `SNES_EXHIROM_SIZE_ADDR + `SNES_COPIER_HDR;
				ram_addr = `SNES_EXHIROM_RAM_ADDR + `SNES_COPIER_HDR;
				layout_forced = 1'b1;
			end
			default: begin
				layout_forced = 1'b0;
			end
		endcase
	end

	// ==============================
	// Header capture
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			rom_type <= 8'd0;
			rom_region <= 1'b0;
			rom_size <= `SNES_DEFAULT_ROM_SIZE;
			ram_size <= 4'd0;
		end else if (hdr_wr) begin
			if (ioctl_addr == '0) begin
				rom_size <= `SNES_DEFAULT_ROM_SIZE;
				ram_size <= 4'd0;
				// Loader puts its own size byte in word 0
				if (header_mode == snes_cart_pkg::HDR_AUTO && ioctl_dout[7:0] != 8'd0) begin
					{ram_size, rom_size} <= ioctl_dout[7:0];
				end
				case (header_mode)
					snes_cart_pkg::HDR_NONE,
					snes_cart_pkg::HDR_LOROM: rom_type <= 8'd0;
					snes_cart_pkg::HDR_HIROM: rom_type <= 8'd1;
					snes_cart_pkg::HDR_EXHIROM: rom_type <= 8'd2;
					default: rom_type <= ioctl_dout[15:8];
				endcase
			end
			if (ioctl_addr == `SNES_ADDR_W'(2)) begin
				rom_region <= ioctl_dout[8];
			end
			if (layout_forced && ioctl_addr == size_addr) begin
				rom_size <= ioctl_dout[11:8];
			end
			if (layout_forced && ioctl_addr == ram_addr) begin
				ram_size <= ioctl_dout[3:0];
			end
		end
	end

	// Masks track the nibbles directly
	assign rom_mask = (mask_base << rom_size) - 1'b1;
	assign ram_mask = (ram_size != 4'd0) ? (mask_base << ram_size) - 1'b1 : '0;

	// Menu setting must be a known layout for the whole download
	a_header_mode_legal: assert property (@(posedge clk_sys) disable iff (!reset)
		cart_download |-> header_mode <= snes_cart_pkg::HDR_EXHIROM)
		else $error("illegal header_mode during cartridge download");

endmodule

// File: hw/cheat_code_loader.sv
`timescale 1ns/100ps
`include "snes_cart_cfg.svh"

module cheat_code_loader (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      code_download,
	input  logic                      cart_download,
	input  logic                      ioctl_wr,
	input  logic [`SNES_ADDR_W-1:0]   ioctl_addr,
	input  logic [`SNES_DATA_W-1:0]   ioctl_dout,
	output logic [`SNES_CHEAT_W-1:0]  cheat_code,
	output logic                      cheat_valid,
	output logic                      cheat_clear
);

	logic       code_wr;
	logic [6:0] slot_lsb;
	logic       list_start;

	assign code_wr = code_download & ioctl_wr;

	// Code word order
	// flags 127:96, address 95:64, compare 63:32, replace 31:0
	// Each field arrives low half first
	assign slot_lsb = {~ioctl_addr[3:2], ioctl_addr[1], 4'b0000};

	// ==============================
	// Code assembly
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			cheat_code[slot_lsb +: `SNES_DATA_W] <= ioctl_dout;
		end
	end

	// Strobe on the last half of the replace field
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			cheat_valid <= 1'b0;
			list_start <= 1'b0;
		end else begin
			cheat_valid <= code_wr & (ioctl_addr[3:0] == 4'd14);
			// First word of a new code list
			list_start <= code_wr & (ioctl_addr == '0);
		end
	end

	// Old codes are dropped for a new list or a new cartridge
	assign cheat_clear = list_start | cart_download;

	a_valid_single: assert property (@(posedge clk_sys) disable iff (!reset)
		cheat_valid |=> !cheat_valid)
		else $error("cheat_valid held for two cycles");

endmodule

// File: hw/backup_ram_sequencer.sv
`timescale 1ns/100ps
`include "snes_cart_cfg.svh"

module backup_ram_sequencer (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        cart_download,
	input  snes_cart_pkg::addr_mask_t   ram_mask,
	input  logic                        img_mounted,
	input  logic                        img_readonly,
	input  logic [63:0]                 img_size,
	input  logic                        sd_ack,
	input  logic                        bsram_write,
	input  logic                        osd_status,
	input  logic                        bk_load_req,
	input  logic                        bk_save_req,
	input  logic                        autosave_en,
	output logic [`SNES_LBA_W-1:0]      sd_lba,
	output logic                        sd_rd,
	output logic                        sd_wr,
	output logic                        bk_busy,
	output logic                        bk_loading,
	output logic                        bk_pending,
	output logic                        bk_enabled
);

	snes_cart_pkg::bk_state_e state;

	logic download_q;
	logic load_q;
	logic save_q;
	logic ack_q;
	logic save_cond;
	logic start_load;
	logic start_save;
	logic ack_rise;
	logic ack_fall;
	logic [`SNES_LBA_W-1:0] sector_limit;

	// Last sector of the battery RAM
	assign sector_limit = {{(`SNES_LBA_W - `SNES_MASK_W + `SNES_SECTOR_SHIFT){1'b0}},
		ram_mask[`SNES_MASK_W-1:`SNES_SECTOR_SHIFT]};

	assign bk_busy = (state != snes_cart_pkg::BK_IDLE);
	assign ack_rise = sd_ack & ~ack_q;
	assign ack_fall = ~sd_ack & ack_q;

	// Manual save, or autosave once the menu opens
	assign save_cond = bk_save_req | (bk_pending & osd_status & autosave_en);

	// Auto-load right after a cartridge download
	assign start_load = bk_enabled & ((bk_load_req & ~load_q) |
		(download_q & ~cart_download & (|img_size)));
	assign start_save = bk_enabled & save_cond & ~save_q & ~start_load;

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			download_q <= 1'b0;
			load_q <= 1'b0;
			save_q <= 1'b0;
			ack_q <= 1'b0;
		end else begin
			download_q <= cart_download;
			load_q <= bk_load_req;
			save_q <= save_cond;
			ack_q <= sd_ack;
		end
	end

	// ==============================
	// Enable and pending flag
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			bk_enabled <= 1'b0;
		end else begin
			if (cart_download && !download_q) begin
				bk_enabled <= 1'b0;
			end
			// Save file is mounted by the end of the download
			if (cart_download && img_mounted && !img_readonly && ram_mask != '0) begin
				bk_enabled <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			bk_pending <= 1'b0;
		end else if (bk_enabled && !osd_status && bsram_write) begin
			bk_pending <= 1'b1;
		end else if (bk_busy) begin
			bk_pending <= 1'b0;
		end
	end

	// ==============================
	// Sector transfer FSM
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			state <= snes_cart_pkg::BK_IDLE;
			sd_lba <= '0;
			sd_rd <= 1'b0;
			sd_wr <= 1'b0;
			bk_loading <= 1'b0;
		end else begin
			case (state)
				snes_cart_pkg::BK_IDLE: begin
					if (start_load || start_save) begin
						state <= snes_cart_pkg::BK_WAIT_ACK;
						sd_lba <= '0;
						sd_rd <= start_load;
						sd_wr <= start_save;
						bk_loading <= start_load;
					end
				end
				snes_cart_pkg::BK_WAIT_ACK: begin
					// Host took the request
					if (ack_rise) begin
						sd_rd <= 1'b0;
						sd_wr <= 1'b0;
						state <= snes_cart_pkg::BK_WAIT_DONE;
					end
				end
				snes_cart_pkg::BK_WAIT_DONE: begin
					if (ack_fall) begin
						if (sd_lba >= sector_limit) begin
							state <= snes_cart_pkg::BK_IDLE;
							bk_loading <= 1'b0;
						end else begin
							sd_lba <= sd_lba + 1'b1;
							sd_rd <= bk_loading;
							sd_wr <= ~bk_loading;
							state <= snes_cart_pkg::BK_WAIT_ACK;
						end
					end
				end
				default: begin
					state <= snes_cart_pkg::BK_IDLE;
				end
			endcase
		end
	end

	a_req_onehot: assert property (@(posedge clk_sys) disable iff (!reset)
		!(sd_rd && sd_wr))
		else $error("sd_rd and sd_wr both high");

	// Sector address stays inside the battery RAM for the whole transfer
	a_lba_limit: assert property (@(posedge clk_sys) disable iff (!reset)
		bk_busy |-> sd_lba <= sector_limit)
		else $error("sd_lba past last backup RAM sector");

endmodule

// File: hw/snes_cart_ctrl.sv
`timescale 1ns/100ps
`include "snes_cart_cfg.svh"

module snes_cart_ctrl (
	input  logic                          clk_sys,
	input  logic                          reset,
	input  logic                          ioctl_download,
	input  logic [7:0]                    ioctl_index,
	input  logic [`SNES_ADDR_W-1:0]       ioctl_addr,
	input  logic [`SNES_DATA_W-1:0]       ioctl_dout,
	input  logic                          ioctl_wr,
	input  snes_cart_pkg::header_mode_e   header_mode,
	input  logic                          img_mounted,
	input  logic                          img_readonly,
	input  logic [63:0]                   img_size,
	input  logic                          sd_ack,
	input  logic                          bsram_write,
	input  logic                          osd_status,
	input  logic                          bk_load_req,
	input  logic                          bk_save_req,
	input  logic                          autosave_en,
	output logic [7:0]                    rom_type,
	output snes_cart_pkg::addr_mask_t     rom_mask,
	output snes_cart_pkg::addr_mask_t     ram_mask,
	output logic                          rom_region,
	output logic [`SNES_CHEAT_W-1:0]      cheat_code,
	output logic                          cheat_valid,
	output logic                          cheat_clear,
	output logic [`SNES_LBA_W-1:0]        sd_lba,
	output logic                          sd_rd,
	output logic                          sd_wr,
	output logic                          bk_busy,
	output logic                          bk_loading,
	output logic                          bk_pending,
	output logic                          bk_enabled,
	output logic                          system_hold,
	output logic                          led_user
);

	logic code_download;
	logic cart_download;

	// Cheat list uses its own download index
	assign code_download = ioctl_download & (ioctl_index == `SNES_CODE_INDEX);
	assign cart_download = ioctl_download & (ioctl_index != `SNES_CODE_INDEX);

	// Core held while the cartridge or its save is loading
	assign system_hold = cart_download | bk_loading;
	assign led_user = cart_download | (autosave_en & bk_pending);

	rom_header_detect u_header (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cart_download (cart_download),
		.ioctl_wr      (ioctl_wr),
		.ioctl_addr    (ioctl_addr),
		.ioctl_dout    (ioctl_dout),
		.header_mode   (header_mode),
		.rom_type      (rom_type),
		.rom_mask      (rom_mask),
		.ram_mask      (ram_mask),
		.rom_region    (rom_region)
	);

	cheat_code_loader u_cheat (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.code_download (code_download),
		.cart_download (cart_download),
		.ioctl_wr      (ioctl_wr),
		.ioctl_addr    (ioctl_addr),
		.ioctl_dout    (ioctl_dout),
		.cheat_code    (cheat_code),
		.cheat_valid   (cheat_valid),
		.cheat_clear   (cheat_clear)
	);

	backup_ram_sequencer u_backup (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cart_download (cart_download),
		.ram_mask      (ram_mask),
		.img_mounted   (img_mounted),
		.img_readonly  (img_readonly),
		.img_size      (img_size),
		.sd_ack        (sd_ack),
		.bsram_write   (bsram_write),
		.osd_status    (osd_status),
		.bk_load_req   (bk_load_req),
		.bk_save_req   (bk_save_req),
		.autosave_en   (autosave_en),
		.sd_lba        (sd_lba),
		.sd_rd         (sd_rd),
		.sd_wr         (sd_wr),
		.bk_busy       (bk_busy),
		.bk_loading    (bk_loading),
		.bk_pending    (bk_pending),
		.bk_enabled    (bk_enabled)
	);

endmodule

// File: sim/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
	parameter real PERIOD = 20.0,
	parameter int RESET_CYCLES = 2
) (
	output logic clk_sys,
	output logic reset
);

	initial begin
		clk_sys = 1'b0;
		forever #(PERIOD / 2.0) clk_sys = ~clk_sys;
	end

	// Active low, released just after a rising edge
	initial begin
		reset = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		#2;
		reset = 1'b1;
	end

endmodule

// File: sim/snes_cart_ctrl_tb.sv
`timescale 1ns/100ps
`include "snes_cart_cfg.svh"

module snes_cart_ctrl_tb;

	// Longest test is a few hundred cycles, so this leaves a wide margin
	localparam int TIMEOUT_CYCLES = 20000;
	localparam logic [7:0] CART_INDEX = 8'h00;

	logic                          clk_sys;
	logic                          reset;
	logic                          ioctl_download;
	logic [7:0]                    ioctl_index;
	logic [`SNES_ADDR_W-1:0]       ioctl_addr;
	logic [`SNES_DATA_W-1:0]       ioctl_dout;
	logic                          ioctl_wr;
	snes_cart_pkg::header_mode_e   header_mode;
	logic                          img_mounted;
	logic                          img_readonly;
	logic [63:0]                   img_size;
	logic                          sd_ack;
	logic                          bsram_write;
	logic                          osd_status;
	logic                          bk_load_req;
	logic                          bk_save_req;
	logic                          autosave_en;
	logic [7:0]                    rom_type;
	snes_cart_pkg::addr_mask_t     rom_mask;
	snes_cart_pkg::addr_mask_t     ram_mask;
	logic                          rom_region;
	logic [`SNES_CHEAT_W-1:0]      cheat_code;
	logic                          cheat_valid;
	logic                          cheat_clear;
	logic [`SNES_LBA_W-1:0]        sd_lba;
	logic                          sd_rd;
	logic                          sd_wr;
	logic                          bk_busy;
	logic                          bk_loading;
	logic                          bk_pending;
	logic                          bk_enabled;
	logic                          system_hold;
	logic                          led_user;

	// Sector requests seen by the block device model
	logic [`SNES_LBA_W-1:0] lba_log[$];
	logic                   dir_log[$];

	int mismatch_count;
	int failure_count;
	int valid_pulses;
	int cycle_count;

	tb_clock_gen clock_gen (
		.clk_sys (clk_sys),
		.reset   (reset)
	);

	snes_cart_ctrl UUT (.*);

	// ==============================
	// Compare and report
	// ==============================
	task automatic compare_mask(input string name, input snes_cart_pkg::addr_mask_t expected,
		input snes_cart_pkg::addr_mask_t actual);
		if (actual !== expected) begin
			mismatch_count++;
			$display("mismatch at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
		end
	endtask

	task automatic compare_byte(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		if (actual !== expected) begin
			mismatch_count++;
			$display("mismatch at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
		end
	endtask

	task automatic compare_code(input string name, input logic [`SNES_CHEAT_W-1:0] expected,
		input logic [`SNES_CHEAT_W-1:0] actual);
		if (actual !== expected) begin
			mismatch_count++;
			$display("mismatch at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
		end
	endtask

	task automatic compare_lba(input string name, input logic [`SNES_LBA_W-1:0] expected,
		input logic [`SNES_LBA_W-1:0] actual);
		if (actual !== expected) begin
			mismatch_count++;
			$display("mismatch at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
		end
	endtask

	task automatic compare_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			mismatch_count++;
			$display("mismatch at %0t ns: %s expected %b, actual %b", $time, name, expected, actual);
		end
	endtask

	task automatic report_failure(input string what);
		failure_count++;
		$display("error at %0t ns: %s", $time, what);
	endtask

	// 1 KiB times two to the size, minus one
	function automatic snes_cart_pkg::addr_mask_t size_to_mask(input logic [3:0] size);
		size_to_mask = (snes_cart_pkg::addr_mask_t'(1024) << size) - 1;
	endfunction

	// ==============================
	// Drive helpers
	// ==============================
	task automatic next_cycle();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic start_download(input logic [7:0] index);
		next_cycle();
		ioctl_index = index;
		ioctl_download = 1'b1;
	endtask

	task automatic write_word(input logic [`SNES_ADDR_W-1:0] addr, input logic [15:0] data);
		next_cycle();
		ioctl_addr = addr;
		ioctl_dout = data;
		ioctl_wr = 1'b1;
		next_cycle();
		ioctl_wr = 1'b0;
	endtask

	task automatic end_download();
		next_cycle();
		ioctl_download = 1'b0;
		next_cycle();
	endtask

	task automatic wait_idle(input int limit, input logic check_loading);
		int n;
		n = 0;
		while (bk_busy && n < limit) begin
			if (check_loading) begin
				compare_bit("bk_loading", 1'b1, bk_loading);
				compare_bit("system_hold", 1'b1, system_hold);
			end
			next_cycle();
			n++;
		end
		if (bk_busy) begin
			report_failure("backup RAM transfer did not finish in time");
		end
	endtask

	task automatic check_sectors(input int count, input logic expect_write);
		if (lba_log.size() != count) begin
			report_failure($sformatf("expected %0d sector requests, saw %0d",
				count, lba_log.size()));
		end
		for (int i = 0; i < lba_log.size() && i < count; i++) begin
			compare_lba("sd_lba", i, lba_log[i]);
			compare_bit("sd_wr", expect_write, dir_log[i]);
		end
		lba_log.delete();
		dir_log.delete();
	endtask

	// ==============================
	// Directed tests
	// ==============================
	task automatic reset_values_test();
		compare_bit("cheat_valid", 1'b0, cheat_valid);
		compare_bit("cheat_clear", 1'b0, cheat_clear);
		compare_bit("sd_rd", 1'b0, sd_rd);
		compare_bit("sd_wr", 1'b0, sd_wr);
		compare_bit("bk_busy", 1'b0, bk_busy);
		compare_bit("bk_loading", 1'b0, bk_loading);
		compare_bit("bk_pending", 1'b0, bk_pending);
		compare_bit("bk_enabled", 1'b0, bk_enabled);
		compare_bit("rom_region", 1'b0, rom_region);
	endtask

	task automatic auto_header_test();
		header_mode = snes_cart_pkg::HDR_AUTO;
		img_mounted = 1'b1;
		img_size = 64'd0;
		start_download(CART_INDEX);
		write_word(0, 16'h2A1B);
		compare_bit("cheat_clear", 1'b1, cheat_clear);
		write_word(2, 16'h0100);
		end_download();
		compare_byte("rom_type", 8'h2A, rom_type);
		compare_mask("rom_mask", size_to_mask(4'hB), rom_mask);
		compare_mask("ram_mask", size_to_mask(4'h1), ram_mask);
		compare_bit("rom_region", 1'b1, rom_region);
		compare_bit("bk_enabled", 1'b1, bk_enabled);
		compare_bit("bk_busy", 1'b0, bk_busy);
	endtask

	task automatic forced_header_test();
		header_mode = snes_cart_pkg::HDR_HIROM;
		start_download(CART_INDEX);
		write_word(0, 16'h5A5A);
		write_word(`SNES_HIROM_SIZE_ADDR + `SNES_COPIER_HDR, 16'h0A00);
		write_word(`SNES_HIROM_RAM_ADDR + `SNES_COPIER_HDR, 16'h0003);
		end_download();
		compare_byte("rom_type", 8'h01, rom_type);
		compare_mask("rom_mask", size_to_mask(4'hA), rom_mask);
		compare_mask("ram_mask", size_to_mask(4'h3), ram_mask);
		// No header, default sizes and no save image
		header_mode = snes_cart_pkg::HDR_NONE;
		img_mounted = 1'b0;
		start_download(CART_INDEX);
		write_word(0, 16'h5A5A);
		end_download();
		compare_byte("rom_type", 8'h00, rom_type);
		compare_mask("rom_mask", size_to_mask(`SNES_DEFAULT_ROM_SIZE), rom_mask);
		compare_mask("ram_mask", '0, ram_mask);
		compare_bit("bk_enabled", 1'b0, bk_enabled);
		img_mounted = 1'b1;
	endtask

	task automatic cheat_load_test();
		logic [15:0] words [8];
		logic [`SNES_CHEAT_W-1:0] expected;
		int start_pulses;
		for (int i = 0; i < 8; i++) begin
			words[i] = 16'(16'h1357 * (i + 1));
		end
		// Flags, address, compare, replace, each high half over low half
		expected = {words[1], words[0], words[3], words[2],
			words[5], words[4], words[7], words[6]};
		start_pulses = valid_pulses;
		start_download(`SNES_CODE_INDEX);
		for (int i = 0; i < 8; i++) begin
			write_word(2 * i, words[i]);
			compare_bit("cheat_clear", (i == 0), cheat_clear);
			compare_bit("cheat_valid", (i == 7), cheat_valid);
		end
		compare_code("cheat_code", expected, cheat_code);
		end_download();
		compare_bit("cheat_valid", 1'b0, cheat_valid);
		if (valid_pulses - start_pulses != 1) begin
			report_failure($sformatf("expected one cheat_valid pulse, saw %0d",
				valid_pulses - start_pulses));
		end
	endtask

	task automatic auto_load_test();
		int sectors;
		sectors = (size_to_mask(4'h2) >> `SNES_SECTOR_SHIFT) + 1;
		header_mode = snes_cart_pkg::HDR_AUTO;
		img_size = 64'h2000;
		start_download(CART_INDEX);
		write_word(0, 16'h032C);
		end_download();
		compare_bit("sd_rd", 1'b1, sd_rd);
		compare_bit("bk_busy", 1'b1, bk_busy);
		wait_idle(2000, 1'b1);
		compare_bit("system_hold", 1'b0, system_hold);
		check_sectors(sectors, 1'b0);
	endtask

	task automatic autosave_test();
		int sectors;
		sectors = (size_to_mask(4'h2) >> `SNES_SECTOR_SHIFT) + 1;
		autosave_en = 1'b1;
		next_cycle();
		compare_bit("led_user", 1'b0, led_user);
		bsram_write = 1'b1;
		next_cycle();
		bsram_write = 1'b0;
		compare_bit("bk_pending", 1'b1, bk_pending);
		compare_bit("led_user", 1'b1, led_user);
		compare_bit("bk_busy", 1'b0, bk_busy);
		// Menu opens
		next_cycle();
		osd_status = 1'b1;
		next_cycle();
		compare_bit("sd_wr", 1'b1, sd_wr);
		wait_idle(2000, 1'b0);
		compare_bit("bk_pending", 1'b0, bk_pending);
		compare_bit("led_user", 1'b0, led_user);
		check_sectors(sectors, 1'b1);
		osd_status = 1'b0;
	endtask

	task automatic disabled_test();
		int requests;
		img_readonly = 1'b1;
		start_download(CART_INDEX);
		write_word(0, 16'h032C);
		end_download();
		compare_bit("bk_enabled", 1'b0, bk_enabled);
		requests = 0;
		for (int i = 0; i < 200; i++) begin
			bk_load_req = (i >= 2 && i < 6);
			bk_save_req = (i >= 8 && i < 12);
			next_cycle();
			if (sd_rd || sd_wr) begin
				requests++;
			end
		end
		if (requests != 0 || lba_log.size() != 0) begin
			report_failure("backup RAM request issued while backup is disabled");
		end
		img_readonly = 1'b0;
	endtask

	// ==============================
	// Block device and monitors
	// ==============================
	initial begin : ack_model
		int seed_value;
		int delay;
		seed_value = $urandom(32'h8393f457);
		sd_ack = 1'b0;
		forever begin
			@(posedge clk_sys);
			#1;
			if (reset && (sd_rd || sd_wr)) begin
				lba_log.push_back(sd_lba);
				dir_log.push_back(sd_wr);
				delay = 1 + ($urandom % 4);
				repeat (delay) @(posedge clk_sys);
				#2;
				sd_ack = 1'b1;
				// Sector done on the falling edge
				delay = 1 + ($urandom % 4);
				repeat (delay) @(posedge clk_sys);
				#2;
				sd_ack = 1'b0;
			end
		end
	end

	initial begin : valid_monitor
		valid_pulses = 0;
		forever begin
			@(posedge clk_sys);
			#1;
			if (reset && cheat_valid) begin
				valid_pulses++;
			end
		end
	end

	initial begin : watchdog
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk_sys);
			cycle_count++;
		end
		$display("timeout: run stopped after %0d cycles", TIMEOUT_CYCLES);
		$display("tests failed");
		$finish;
	end

	initial begin : main
		mismatch_count = 0;
		failure_count = 0;
		ioctl_download = 1'b0;
		ioctl_index = 8'h00;
		ioctl_addr = '0;
		ioctl_dout = '0;
		ioctl_wr = 1'b0;
		header_mode = snes_cart_pkg::HDR_AUTO;
		img_mounted = 1'b0;
		img_readonly = 1'b0;
		img_size = 64'd0;
		bsram_write = 1'b0;
		osd_status = 1'b0;
		bk_load_req = 1'b0;
		bk_save_req = 1'b0;
		autosave_en = 1'b0;
		wait (reset === 1'b1);
		reset_values_test();
		auto_header_test();
		forced_header_test();
		check_sectors(0, 1'b0);
		cheat_load_test();
		auto_load_test();
		autosave_test();
		disabled_test();
		next_cycle();
		$display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
		if (mismatch_count == 0 && failure_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// File: snes_cart_ctrl.f
+incdir+hw
hw/snes_cart_pkg.sv
hw/rom_header_detect.sv
hw/cheat_code_loader.sv
hw/backup_ram_sequencer.sv
hw/snes_cart_ctrl.sv
sim/tb_clock_gen.sv
sim/snes_cart_ctrl_tb.sv
